// ==== rtl/exePkg.sv ====
// --------------------
// Shared types for the execute stage of the 32-bit pipeline.
// Holds the opcode and branch encodings, the stage bundles and
// the stage constants. Modules import it in their headers.
// --------------------
`default_nettype none

package exePkg;

    localparam int dataW = 32;
    localparam int divSteps = 32;               // one quotient bit per cycle
    localparam logic [4:0] regRa = 5'd31;

    typedef enum logic [4:0] {
        opAdd, opAddu, opSub, opSubu, opAnd, opOr, opXor, opNor,
        opSlt, opSltu, opSll, opSrl, opSra, opLui,
        opMult, opMultu, opDiv, opDivu, opMthi, opMtlo, opNop
    } aluOpT;

    typedef enum logic [2:0] {brNone, brEq, brNe, brGez, brGtz, brLez, brLtz} branchT;
    typedef enum logic [1:0] {stNone, stByte, stHalf, stWord} storeT;
    typedef enum logic [1:0] {ldNone, ldByte, ldHalf, ldWord} loadT;
    typedef enum logic [1:0] {dstRd, dstRt, dstRa} dstSelT;
    typedef enum logic [1:0] {readGpr, readHi, readLo} readSelT;

    typedef struct packed {
        logic gpr;
        logic hi;
        logic lo;
    } regsWrT;

    typedef struct packed {
        logic ovf;
        logic adEl;                             // load address error
        logic adEs;                             // store address error
    } exceptT;

    // what a later stage is about to write back
    typedef struct packed {
        logic             regsWr;
        logic [4:0]       dst;
        logic [dataW-1:0] result;
    } fwdSrcT;

    typedef struct packed {
        logic [dataW-1:0] busA;
        logic [dataW-1:0] busB;
        logic [dataW-1:0] imm32;
        logic [dataW-1:0] pc;
        logic [4:0]       rs;
        logic [4:0]       rt;
        logic [4:0]       rd;
        logic [4:0]       shamt;
        aluOpT            aluOp;
        logic             srcAShamt;
        logic             srcBImm;
        dstSelT           dstSel;
        regsWrT           regsWr;
        readSelT          readSel;
        branchT           branch;
        loadT             load;
        storeT            store;
        exceptT           except;
    } idExeT;

    typedef struct packed {
        idExeT id;
        logic  fresh;
        logic  valid;
    } exeRegT;

    typedef struct packed {
        logic [dataW-1:0] pc;
        logic [dataW-1:0] aluOut;
        logic [dataW-1:0] outB;
        logic [4:0]       dst;
        regsWrT           regsWr;
        loadT             load;
        storeT            store;
        exceptT           except;
        logic [3:0]       dcacheWen;
    } exeMemT;

endpackage

`default_nettype wire

// ==== rtl/exeReg.sv ====
// --------------------
// Decode to execute pipeline register.
// Loads on exeWr, turns the slot into a bubble on exeFlush and
// raises fresh for the first cycle of every loaded instruction.
// --------------------
`timescale 1ns/10ps
`default_nettype none

module exeReg import exePkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  logic   exeWr,
    input  logic   exeFlush,
    input  idExeT  idIn,
    output exeRegT exeQ
);

    // clear everything that could change machine state
    function automatic idExeT bubble(input idExeT d);
        idExeT b;
        b = d;
        b.aluOp  = opNop;
        b.regsWr = '0;
        b.branch = brNone;
        b.load   = ldNone;
        b.store  = stNone;
        b.except = '0;
        return b;
    endfunction

    always_ff @(posedge clk) begin
        if (!rstN) begin
            exeQ.id    <= bubble(exeQ.id);
            exeQ.fresh <= 1'b0;
            exeQ.valid <= 1'b0;
        end else if (exeFlush) begin            // flush wins over exeWr
            exeQ.id    <= bubble(idIn);
            exeQ.fresh <= 1'b0;
            exeQ.valid <= 1'b0;
        end else if (exeWr) begin
            exeQ.id    <= idIn;
            exeQ.fresh <= 1'b1;
            exeQ.valid <= 1'b1;
        end else begin
            exeQ.fresh <= 1'b0;                 // held instruction is stale
        end
    end

endmodule

`default_nettype wire

// ==== rtl/operandForward.sv ====
// --------------------
// Operand bypass for the execute stage.
// Memory stage wins over write-back, register 0 is never bypassed.
// Also picks ALU sources, the outB source and the destination.
// --------------------
`timescale 1ns/10ps
`default_nettype none

module operandForward import exePkg::*; (
    input  exeRegT           exeQ,
    input  fwdSrcT           memFwd,
    input  fwdSrcT           wbFwd,
    input  logic [dataW-1:0] hiVal,
    input  logic [dataW-1:0] loVal,
    output logic [dataW-1:0] fwdA,
    output logic [dataW-1:0] fwdB,
    output logic [dataW-1:0] aluA,
    output logic [dataW-1:0] aluB,
    output logic [dataW-1:0] outB,
    output logic [4:0]       dst
);

    function automatic logic [dataW-1:0] pick(input logic [4:0] src,
                                              input logic [dataW-1:0] bus,
                                              input fwdSrcT mem,
                                              input fwdSrcT wb);
        if (mem.regsWr && mem.dst == src && src != 5'd0)
            return mem.result;
        if (wb.regsWr && wb.dst == src && src != 5'd0)
            return wb.result;
        return bus;
    endfunction

    assign fwdA = pick(exeQ.id.rs, exeQ.id.busA, memFwd, wbFwd);
    assign fwdB = pick(exeQ.id.rt, exeQ.id.busB, memFwd, wbFwd);

    assign aluA = exeQ.id.srcAShamt ? {{(dataW-5){1'b0}}, exeQ.id.shamt} : fwdA;
    assign aluB = exeQ.id.srcBImm ? exeQ.id.imm32 : fwdB;

    always_comb begin
        case (exeQ.id.readSel)
            readHi:  outB = hiVal;              // MFHI
            readLo:  outB = loVal;              // MFLO
            default: outB = fwdB;
        endcase
        case (exeQ.id.dstSel)
            dstRt:   dst = exeQ.id.rt;
            dstRa:   dst = regRa;               // link register
            default: dst = exeQ.id.rd;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/branchResolve.sv ====
// --------------------
// Branch decision on the bypassed operands.
// taken drives the flush of the younger fetch and decode slots.
// --------------------
`timescale 1ns/10ps
`default_nettype none

module branchResolve import exePkg::*; (
    input  exeRegT           exeQ,
    input  logic [dataW-1:0] fwdA,
    input  logic [dataW-1:0] fwdB,
    output logic             taken
);

    logic cond;
    logic aZero;

    assign aZero = (fwdA == '0);

    always_comb begin
        case (exeQ.id.branch)
            brEq:    cond = (fwdA == fwdB);
            brNe:    cond = (fwdA != fwdB);
            brGez:   cond = !fwdA[dataW-1];
            brGtz:   cond = !fwdA[dataW-1] && !aZero;
            brLez:   cond = fwdA[dataW-1] || aZero;
            brLtz:   cond = fwdA[dataW-1];   // sign bit only
            default: cond = 1'b0;
        endcase
    end

    assign taken = exeQ.valid && cond;

endmodule

`default_nettype wire

// ==== rtl/aluUnit.sv ====
// --------------------
// Integer ALU of the execute stage.
// Shift amount comes from aluA, shifted data from aluB.
// Signed add and subtract raise ovf in the exception bundle.
// --------------------
`timescale 1ns/10ps
`default_nettype none

module aluUnit import exePkg::*; (
    input  aluOpT            aluOp,
    input  logic [dataW-1:0] aluA,
    input  logic [dataW-1:0] aluB,
    input  exceptT           exceptIn,
    output logic [dataW-1:0] aluOut,
    output exceptT           exceptOut
);

    logic [dataW-1:0] sum;
    logic [dataW-1:0] diff;
    logic [4:0]       sa;
    logic             addOvf;
    logic             subOvf;
    logic             ovf;

    assign sum  = aluA + aluB;
    assign diff = aluA - aluB;
    assign sa   = aluA[4:0];

    // same signs in, other sign out
    assign addOvf = (aluA[dataW-1] == aluB[dataW-1]) && (sum[dataW-1] != aluA[dataW-1]);
    assign subOvf = (aluA[dataW-1] != aluB[dataW-1]) && (diff[dataW-1] != aluA[dataW-1]);

    always_comb begin
        ovf = 1'b0;
        case (aluOp)
            opAdd:   begin aluOut = sum;  ovf = addOvf; end
            opAddu:  aluOut = sum;
            opSub:   begin aluOut = diff; ovf = subOvf; end
            opSubu:  aluOut = diff;
            opAnd:   aluOut = aluA & aluB;
            opOr:    aluOut = aluA | aluB;
            opXor:   aluOut = aluA ^ aluB;
            opNor:   aluOut = ~(aluA | aluB);
            opSlt:   aluOut = {{(dataW-1){1'b0}}, $signed(aluA) < $signed(aluB)};
            opSltu:  aluOut = {{(dataW-1){1'b0}}, aluA < aluB};
            opSll:   aluOut = aluB << sa;
            opSrl:   aluOut = aluB >> sa;
            opSra:   aluOut = $signed(aluB) >>> sa;
            opLui:   aluOut = {aluB[15:0], 16'h0000};
            default: aluOut = '0;               // mult/div, move-to, nop
        endcase
    end

    always_comb begin
        exceptOut     = exceptIn;
        exceptOut.ovf = exceptIn.ovf | ovf;
    end

endmodule

`default_nettype wire

// ==== rtl/multDiv.sv ====
// --------------------
// Multiply and divide unit.
// Multiply settles in one cycle, divide takes one quotient bit per
// cycle on the operand magnitudes. mdStall holds the pipeline,
// mdFinish marks the cycle where mdHi and mdLo are final.
// --------------------
`timescale 1ns/10ps
`default_nettype none

module multDiv import exePkg::*; (
    input  logic             clk,
    input  logic             rstN,
    input  exeRegT           exeQ,
    input  logic [dataW-1:0] fwdA,
    input  logic [dataW-1:0] fwdB,
    input  logic             hiLoKeep,
    output logic             mdStall,
    output logic             mdFinish,
    output logic [dataW-1:0] mdHi,
    output logic [dataW-1:0] mdLo
);

    typedef enum logic [1:0] {sIdle, sMul, sDiv} mdStateT;

    mdStateT                 state;
    logic [5:0]              cnt;
    logic [dataW-1:0]        rem;
    logic [dataW-1:0]        quo;
    logic [dataW-1:0]        dvs;
    logic                    negQ;
    logic                    negR;
    logic                    start;
    logic                    mulOp;
    logic                    signedOp;
    logic [dataW-1:0]        magA;
    logic [dataW-1:0]        magB;
    logic signed [2*dataW-1:0] prodS;
    logic [2*dataW-1:0]      prodU;
    logic [2*dataW-1:0]      firstStep;

    // shift in the next dividend bit, subtract if it fits
    function automatic logic [2*dataW-1:0] divStep(input logic [dataW-1:0] r,
                                                   input logic [dataW-1:0] q,
                                                   input logic [dataW-1:0] d);
        logic [dataW:0] sh;
        logic [dataW:0] trial;
        sh    = {r, q[dataW-1]};
        trial = sh - {1'b0, d};
        if (trial[dataW])
            return {sh[dataW-1:0], q[dataW-2:0], 1'b0};
        return {trial[dataW-1:0], q[dataW-2:0], 1'b1};
    endfunction

    assign start    = exeQ.fresh && (exeQ.id.aluOp inside {opMult, opMultu, opDiv, opDivu});
    assign mulOp    = exeQ.id.aluOp inside {opMult, opMultu};
    assign signedOp = exeQ.id.aluOp inside {opMult, opDiv};
    assign magA     = (signedOp && fwdA[dataW-1]) ? -fwdA : fwdA;
    assign magB     = (signedOp && fwdB[dataW-1]) ? -fwdB : fwdB;
    assign prodS    = $signed(fwdA) * $signed(fwdB);
    assign prodU    = fwdA * fwdB;
    assign firstStep = divStep('0, magA, magB);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= sIdle;
            cnt   <= '0;
        end else if (!hiLoKeep) begin
            state <= sIdle;                     // abort, results dropped
        end else begin
            case (state)
                sIdle: if (start) begin
                    if (mulOp) begin
                        {rem, quo} <= signedOp ? prodS : prodU;
                        negQ  <= 1'b0;
                        negR  <= 1'b0;
                        state <= sMul;
                    end else begin
                        {rem, quo} <= firstStep;    // first bit on the start edge
                        dvs   <= magB;
                        negQ  <= signedOp && (fwdA[dataW-1] ^ fwdB[dataW-1]);
                        negR  <= signedOp && fwdA[dataW-1];
                        cnt   <= 6'd1;
                        state <= sDiv;
                    end
                end
                sMul: state <= sIdle;
                sDiv: if (cnt == 6'(divSteps)) begin
                    state <= sIdle;
                end else begin
                    {rem, quo} <= divStep(rem, quo, dvs);
                    cnt <= cnt + 6'd1;
                end
                default: state <= sIdle;
            endcase
        end
    end

    assign mdStall  = (state == sIdle && start) || (state == sDiv && cnt != 6'(divSteps));
    assign mdFinish = (state == sMul) || (state == sDiv && cnt == 6'(divSteps));
    assign mdHi     = negR ? -rem : rem;        // remainder follows dividend sign
    assign mdLo     = negQ ? -quo : quo;

endmodule

`default_nettype wire

// ==== rtl/hiLoRegs.sv ====
// --------------------
// HI and LO registers.
// Written by a multiply/divide finish or by MTHI and MTLO,
// nothing is written while hiLoKeep is low.
// --------------------
`timescale 1ns/10ps
`default_nettype none

module hiLoRegs import exePkg::*; (
    input  logic             clk,
    input  logic             rstN,
    input  exeRegT           exeQ,
    input  logic [dataW-1:0] fwdA,
    input  logic             mdFinish,
    input  logic [dataW-1:0] mdHi,
    input  logic [dataW-1:0] mdLo,
    input  logic             hiLoKeep,
    output logic [dataW-1:0] hiVal,
    output logic [dataW-1:0] loVal
);

    logic moveHi;
    logic moveLo;

    assign moveHi = exeQ.id.regsWr.hi && exeQ.id.aluOp == opMthi;
    assign moveLo = exeQ.id.regsWr.lo && exeQ.id.aluOp == opMtlo;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            hiVal <= '0;
            loVal <= '0;
        end else if (hiLoKeep) begin
            if (mdFinish) begin
                hiVal <= mdHi;
                loVal <= mdLo;
            end else begin
                if (moveHi) hiVal <= fwdA;
                if (moveLo) loVal <= fwdA;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/storeEnable.sv ====
// --------------------
// Data cache byte write enables and address alignment check.
// A faulting or invalid slot never writes the cache.
// --------------------
`timescale 1ns/10ps
`default_nettype none

module storeEnable import exePkg::*; (
    input  exeRegT           exeQ,
    input  logic [dataW-1:0] aluOut,
    input  exceptT           exceptIn,
    output exceptT           exceptOut,
    output logic [3:0]       dcacheWen
);

    logic [1:0] addr;
    logic       halfBad;
    logic       wordBad;
    logic [3:0] mask;

    assign addr    = aluOut[1:0];
    assign halfBad = addr[0];
    assign wordBad = (addr != 2'b00);

    always_comb begin
        case (exeQ.id.store)
            stByte:  mask = 4'b0001 << addr;
            stHalf:  mask = addr[1] ? 4'b1100 : 4'b0011;
            stWord:  mask = 4'b1111;
            default: mask = 4'b0000;
        endcase
        exceptOut      = exceptIn;
        exceptOut.adEs = exceptIn.adEs | (exeQ.id.store == stHalf && halfBad)
                                       | (exeQ.id.store == stWord && wordBad);
        exceptOut.adEl = exceptIn.adEl | (exeQ.id.load == ldHalf && halfBad)
                                       | (exeQ.id.load == ldWord && wordBad);
    end

    assign dcacheWen = (exeQ.valid && !(|exceptOut)) ? mask : 4'b0000;

endmodule

`default_nettype wire

// ==== rtl/exeStage.sv ====
// --------------------
// Execute stage top level.
// Takes the decoded instruction and the bypass buses, returns the
// execute-to-memory bundle, the branch flush and the mult/div stall.
// busAFwd feeds fetch for register jumps.
// --------------------
`timescale 1ns/10ps
`default_nettype none

module exeStage import exePkg::*; (
    input  logic             clk,
    input  logic             rstN,
    input  logic             exeWr,
    input  logic             exeFlush,
    input  logic             hiLoKeep,
    input  idExeT            idIn,
    input  fwdSrcT           memFwd,
    input  fwdSrcT           wbFwd,
    output exeMemT           exeOut,
    output logic             branchFlush,
    output logic             mdStall,
    output logic [dataW-1:0] busAFwd
);

    exeRegT           exeQ;
    logic [dataW-1:0] fwdA;
    logic [dataW-1:0] fwdB;
    logic [dataW-1:0] aluA;
    logic [dataW-1:0] aluB;
    logic [dataW-1:0] outB;
    logic [4:0]       dst;
    logic [dataW-1:0] aluOut;
    exceptT           aluExcept;            // after overflow check
    exceptT           finalExcept;          // after alignment check
    logic [3:0]       dcacheWen;
    logic             mdFinish;
    logic [dataW-1:0] mdHi;
    logic [dataW-1:0] mdLo;
    logic [dataW-1:0] hiVal;
    logic [dataW-1:0] loVal;

    exeReg uExeReg (.clk, .rstN, .exeWr, .exeFlush, .idIn, .exeQ);

    operandForward uFwd (
        .exeQ, .memFwd, .wbFwd, .hiVal, .loVal,
        .fwdA, .fwdB, .aluA, .aluB, .outB, .dst
    );

    branchResolve uBranch (.exeQ, .fwdA, .fwdB, .taken(branchFlush));

    aluUnit uAlu (
        .aluOp(exeQ.id.aluOp), .aluA, .aluB, .exceptIn(exeQ.id.except),
        .aluOut, .exceptOut(aluExcept)
    );

    multDiv uMultDiv (
        .clk, .rstN, .exeQ, .fwdA, .fwdB, .hiLoKeep,
        .mdStall, .mdFinish, .mdHi, .mdLo
    );

    hiLoRegs uHiLo (
        .clk, .rstN, .exeQ, .fwdA, .mdFinish, .mdHi, .mdLo, .hiLoKeep,
        .hiVal, .loVal
    );

    storeEnable uStore (
        .exeQ, .aluOut, .exceptIn(aluExcept), .exceptOut(finalExcept), .dcacheWen
    );

    assign busAFwd = fwdA;

    assign exeOut = '{
        pc:        exeQ.id.pc,
        aluOut:    aluOut,
        outB:      outB,
        dst:       dst,
        regsWr:    exeQ.id.regsWr,
        load:      exeQ.id.load,
        store:     exeQ.id.store,
        except:    finalExcept,
        dcacheWen: dcacheWen
    };

endmodule

`default_nettype wire

// ==== sim/exeStageTb.sv ====
// --------------------
// Testbench for the execute stage.
// Acts as decode, memory and write-back around the DUT. It drives
// random instructions and bypass values on the falling edge and
// checks the outputs against reference models.
// --------------------
`timescale 1ns/10ps
`default_nettype none

module exeStageTb import exePkg::*; ();

    localparam int nAlu = 300;
    localparam int nBranch = 150;
    localparam int nMd = 60;
    localparam int nAbort = 10;
    localparam int nMem = 150;
    // worst case is a full divide per instruction at 4 ns a cycle
    localparam int timeoutNs = (nAlu + nBranch + 3 * nMd + 7 * nAbort + nMem) * 33 * 4 + 400;

    logic             clk = 1'b0;
    logic             rstN;
    logic             exeWr;
    logic             exeFlush;
    logic             hiLoKeep;
    idExeT            idIn;
    fwdSrcT           memFwd;
    fwdSrcT           wbFwd;
    exeMemT           exeOut;
    logic             branchFlush;
    logic             mdStall;
    logic [dataW-1:0] busAFwd;
    logic [31:0]      seed = 32'hdc2c_494d;
    logic [31:0]      hiM;                  // expected HI
    logic [31:0]      loM;                  // expected LO

    exeStage DUT (
        .clk, .rstN, .exeWr, .exeFlush, .hiLoKeep, .idIn, .memFwd, .wbFwd,
        .exeOut, .branchFlush, .mdStall, .busAFwd
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] rand32();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    task automatic stopRun(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            stopRun($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // memory stage wins and register 0 is never bypassed
    function automatic logic [31:0] fwdRef(input logic [4:0] src, input logic [31:0] bus);
        if (src != 5'd0 && memFwd.regsWr && memFwd.dst == src)
            return memFwd.result;
        if (src != 5'd0 && wbFwd.regsWr && wbFwd.dst == src)
            return wbFwd.result;
        return bus;
    endfunction

    function automatic logic [32:0] aluRef(input aluOpT op, input logic [31:0] a,
                                           input logic [31:0] b);
        logic [32:0] s;
        logic [31:0] r;
        logic        ovf;
        int          sb;
        sb = b;
        ovf = 1'b0;
        case (op)
            opAdd: begin
                s = {a[31], a} + {b[31], b};
                r = s[31:0];
                ovf = s[32] ^ s[31];        // sign-extended sum disagrees
            end
            opSub: begin
                s = {a[31], a} - {b[31], b};
                r = s[31:0];
                ovf = s[32] ^ s[31];
            end
            opAddu: r = a + b;
            opSubu: r = a - b;
            opAnd:  r = a & b;
            opOr:   r = a | b;
            opXor:  r = a ^ b;
            opNor:  r = ~(a | b);
            opSlt:  r = {31'b0, $signed(a) < $signed(b)};
            opSltu: r = {31'b0, a < b};
            opSll:  r = b << a[4:0];
            opSrl:  r = b >> a[4:0];
            opSra:  r = sb >>> a[4:0];
            opLui:  r = {b[15:0], 16'h0000};
            default: r = '0;
        endcase
        return {ovf, r};
    endfunction

    function automatic logic [63:0] mdRef(input aluOpT op, input logic [31:0] a,
                                          input logic [31:0] b);
        longint sa;
        longint sb;
        int     ia;
        int     ib;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        ia = a;
        ib = b;
        case (op)
            opMult:  return sa * sb;
            opMultu: return {32'b0, a} * {32'b0, b};
            opDiv:   return {32'(ia % ib), 32'(ia / ib)};   // {remainder, quotient}
            default: return {a % b, a / b};
        endcase
    endfunction

    function automatic logic brRef(input branchT kind, input logic [31:0] a,
                                   input logic [31:0] b);
        int sa;
        sa = a;
        case (kind)
            brEq:    return a == b;
            brNe:    return a != b;
            brGez:   return sa >= 0;
            brGtz:   return sa > 0;
            brLez:   return sa <= 0;
            brLtz:   return sa < 0;
            default: return 1'b0;
        endcase
    endfunction

    // {adEl, adEs, byte enables}
    function automatic logic [5:0] memRef(input storeT st, input loadT ld, input logic [1:0] a);
        logic [3:0] m;
        logic       es;
        logic       el;
        m = 4'b0000;
        es = 1'b0;
        el = 1'b0;
        case (st)
            stByte: m = 4'b0001 << a;
            stHalf: begin
                m = a[1] ? 4'b1100 : 4'b0011;
                es = a[0];
            end
            stWord: begin
                m = 4'b1111;
                es = (a != 2'b00);
            end
            default: m = 4'b0000;
        endcase
        if (ld == ldHalf)
            el = a[0];
        if (ld == ldWord)
            el = (a != 2'b00);
        if (es || el)
            m = 4'b0000;
        return {el, es, m};
    endfunction

    function automatic idExeT blankIns();
        idExeT ins;
        ins = '0;
        ins.aluOp = opNop;
        return ins;
    endfunction

    task automatic randomFwd(input logic [4:0] rs, input logic [4:0] rt);
        logic [31:0] r;
        r = rand32();
        memFwd.regsWr = r[0];
        memFwd.dst = r[1] ? rs : (r[2] ? rt : r[7:3]);
        memFwd.result = rand32();
        wbFwd.regsWr = r[8];
        wbFwd.dst = r[9] ? rs : (r[10] ? rt : r[15:11]);
        wbFwd.result = rand32();
    endtask

    // starts and ends on a falling edge with the load in between
    task automatic issue(input idExeT ins, input logic flush);
        idIn = ins;
        exeWr = 1'b1;
        exeFlush = flush;
        @(posedge clk);
        @(negedge clk);
        exeWr = 1'b0;
        exeFlush = 1'b0;
    endtask

    task automatic readBack();
        idExeT ins;
        ins = blankIns();
        ins.readSel = readHi;
        issue(ins, 1'b0);
        checkVal("exeOut.outB (HI)", exeOut.outB, hiM);
        ins.readSel = readLo;
        issue(ins, 1'b0);
        checkVal("exeOut.outB (LO)", exeOut.outB, loM);
    endtask

    task automatic aluTest(input int n);
        idExeT       ins;
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] expB;
        logic [4:0]  expDst;
        logic [32:0] exp;
        logic        shift;
        logic        flush;
        int          i;
        for (i = 0; i < n; i++) begin
            r = rand32();
            ins = blankIns();
            ins.aluOp = aluOpT'(r % 14);
            shift = (ins.aluOp == opSll) || (ins.aluOp == opSrl) || (ins.aluOp == opSra);
            ins.rs = (r[7:5] == 3'd0) ? 5'd0 : r[12:8];
            ins.rt = r[17:13];
            ins.rd = r[22:18];
            ins.shamt = r[27:23];
            ins.srcAShamt = shift && r[28];
            ins.srcBImm = !shift && r[29];
            ins.busA = rand32();
            ins.busB = rand32();
            ins.imm32 = rand32();
            ins.pc = rand32();
            ins.dstSel = dstSelT'(rand32() % 3);
            ins.regsWr.gpr = 1'b1;
            flush = (r[31:30] == 2'b11) && r[4];
            randomFwd(ins.rs, ins.rt);
            a = ins.srcAShamt ? {27'b0, ins.shamt} : fwdRef(ins.rs, ins.busA);
            b = ins.srcBImm ? ins.imm32 : fwdRef(ins.rt, ins.busB);
            expB = fwdRef(ins.rt, ins.busB);
            case (ins.dstSel)
                dstRt:   expDst = ins.rt;
                dstRa:   expDst = 5'd31;    // link register
                default: expDst = ins.rd;
            endcase
            exp = aluRef(ins.aluOp, a, b);
            issue(ins, flush);
            if (flush) begin
                checkVal("exeOut.regsWr", exeOut.regsWr, 32'd0);
                checkVal("exeOut.aluOut", exeOut.aluOut, 32'd0);
            end else begin
                checkVal("exeOut.aluOut", exeOut.aluOut, exp[31:0]);
                checkVal("exeOut.except.ovf", exeOut.except.ovf, exp[32]);
                checkVal("exeOut.regsWr", exeOut.regsWr, 32'd4);
                checkVal("exeOut.outB", exeOut.outB, expB);
                checkVal("exeOut.dst", exeOut.dst, expDst);
                checkVal("exeOut.pc", exeOut.pc, ins.pc);
            end
        end
    endtask

    task automatic branchTest(input int n);
        idExeT       ins;
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        int          i;
        for (i = 0; i < n; i++) begin
            r = rand32();
            ins = blankIns();
            ins.branch = branchT'(1 + r % 6);
            ins.rs = r[12:8];
            ins.rt = r[17:13];
            ins.busA = rand32();
            ins.busB = rand32();
            if (r[21:19] == 3'd0) begin
                ins.rs = 5'd0;              // zero operand for the gtz/lez edges
                ins.busA = '0;
            end
            if (r[22]) begin
                ins.rt = ins.rs;
                ins.busB = ins.busA;
            end
            randomFwd(ins.rs, ins.rt);
            a = fwdRef(ins.rs, ins.busA);
            b = fwdRef(ins.rt, ins.busB);
            issue(ins, 1'b0);
            checkVal("branchFlush", branchFlush, brRef(ins.branch, a, b));
            checkVal("busAFwd", busAFwd, a);
        end
    endtask

    task automatic mdTest(input int n);
        idExeT       ins;
        logic [31:0] r;
        logic [63:0] exp;
        logic        isMul;
        int          cnt;
        int          i;
        for (i = 0; i < n; i++) begin
            r = rand32();
            ins = blankIns();
            ins.aluOp = aluOpT'(int'(opMult) + r % 4);
            isMul = (ins.aluOp == opMult) || (ins.aluOp == opMultu);
            ins.regsWr.hi = 1'b1;
            ins.regsWr.lo = 1'b1;
            ins.rs = r[8:4];
            ins.rt = r[13:9];
            ins.busA = rand32();
            ins.busB = isMul ? rand32() : (rand32() >> r[20:16]);
            if (ins.busB == '0)
                ins.busB = 32'd1;
            if (ins.busA == 32'h8000_0000 && ins.busB == '1)
                ins.busB = 32'd3;
            memFwd.regsWr = 1'b0;
            wbFwd.regsWr = 1'b0;
            exp = mdRef(ins.aluOp, fwdRef(ins.rs, ins.busA), fwdRef(ins.rt, ins.busB));
            issue(ins, 1'b0);
            cnt = 0;
            while (mdStall) begin
                cnt++;
                @(negedge clk);
            end
            checkVal("mdStall cycles", cnt, isMul ? 1 : divSteps);
            hiM = exp[63:32];
            loM = exp[31:0];
            readBack();
        end
    endtask

    task automatic abortTest(input int n);
        idExeT       ins;
        logic [31:0] r;
        int          i;
        for (i = 0; i < n; i++) begin
            r = rand32();
            ins = blankIns();
            ins.aluOp = r[0] ? opDiv : opDivu;
            ins.regsWr.hi = 1'b1;
            ins.regsWr.lo = 1'b1;
            ins.busA = rand32();
            ins.busB = rand32() | 32'd1;
            issue(ins, 1'b0);
            // last abort lands on the finish cycle
            repeat ((i == n - 1) ? divSteps : 1 + r[8:4] % 20) @(negedge clk);
            hiLoKeep = 1'b0;
            @(posedge clk);
            @(negedge clk);
            hiLoKeep = 1'b1;
            checkVal("mdStall", mdStall, 32'd0);
            readBack();
            // both moves see the same bypass values
            ins = blankIns();
            ins.rs = r[13:9];
            ins.busA = rand32();
            randomFwd(ins.rs, r[18:14]);
            ins.aluOp = opMthi;
            ins.regsWr.hi = 1'b1;
            issue(ins, 1'b0);
            hiM = fwdRef(ins.rs, ins.busA);
            ins.aluOp = opMtlo;
            ins.regsWr = '0;
            ins.regsWr.lo = 1'b1;
            ins.busA = ~ins.busA;
            issue(ins, 1'b0);
            loM = fwdRef(ins.rs, ins.busA);
            readBack();
        end
    endtask

    task automatic memTest(input int n);
        idExeT       ins;
        logic [31:0] r;
        logic [31:0] addr;
        logic [5:0]  exp;
        int          i;
        for (i = 0; i < n; i++) begin
            r = rand32();
            ins = blankIns();
            ins.aluOp = opAddu;
            ins.srcBImm = 1'b1;
            ins.imm32 = {24'b0, r[15:8]};
            ins.rs = r[20:16];
            ins.busA = rand32();
            if (r[0])
                ins.store = storeT'(r[2:1]);
            else
                ins.load = loadT'(r[2:1]);
            randomFwd(ins.rs, r[25:21]);
            addr = fwdRef(ins.rs, ins.busA) + ins.imm32;
            exp = memRef(ins.store, ins.load, addr[1:0]);
            issue(ins, 1'b0);
            checkVal("exeOut.aluOut", exeOut.aluOut, addr);
            checkVal("exeOut.dcacheWen", exeOut.dcacheWen, exp[3:0]);
            checkVal("exeOut.except.adEs", exeOut.except.adEs, exp[4]);
            checkVal("exeOut.except.adEl", exeOut.except.adEl, exp[5]);
            checkVal("exeOut.store", exeOut.store, ins.store);
            checkVal("exeOut.load", exeOut.load, ins.load);
        end
    endtask

    initial begin
        #(timeoutNs);
        stopRun("watchdog timeout, the run did not finish in time");
    end

    initial begin
        rstN = 1'b0;
        exeWr = 1'b0;
        exeFlush = 1'b0;
        hiLoKeep = 1'b1;
        idIn = blankIns();
        memFwd = '0;
        wbFwd = '0;
        hiM = '0;
        loM = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        checkVal("exeOut.dcacheWen", exeOut.dcacheWen, 32'd0);
        checkVal("branchFlush", branchFlush, 32'd0);
        checkVal("mdStall", mdStall, 32'd0);
        aluTest(nAlu);
        branchTest(nBranch);
        mdTest(nMd);
        abortTest(nAbort);
        memTest(nMem);
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
rtl/exePkg.sv
rtl/exeReg.sv
rtl/operandForward.sv
rtl/branchResolve.sv
rtl/aluUnit.sv
rtl/multDiv.sv
rtl/hiLoRegs.sv
rtl/storeEnable.sv
rtl/exeStage.sv
sim/exeStageTb.sv

// ==== Bender.yml ====
package:
  name: exe_stage

sources:
  - files:
      - rtl/exePkg.sv
      - rtl/exeReg.sv
      - rtl/operandForward.sv
      - rtl/branchResolve.sv
      - rtl/aluUnit.sv
      - rtl/multDiv.sv
      - rtl/hiLoRegs.sv
      - rtl/storeEnable.sv
      - rtl/exeStage.sv
  - target: simulation
    files:
      - sim/exeStageTb.sv
